// ==== Makefile ====
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decodeStageTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^SIMULATION PASSED$$" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/decodeStageTb.sv ====
`default_nettype none

module decodeStageTb import decodePkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned tableLen    = 32;
    localparam int unsigned preloadLen  = 64;   // 32 writes, then 32 probe reads
    localparam int unsigned cycleLimit  = 2 * tableLen + preloadLen + 100;
    localparam int unsigned stallCycles = 4;

    typedef struct packed {
        logic [dataWidth-1:0]    instr;
        logic [dataWidth-1:0]    instrAddr;
        ctrlBundle               ctrl;
        logic [dataWidth-1:0]    imm;
        logic [regAddrWidth-1:0] dest;
    } tableEntry;

    // Entry plus the counters seen when it was driven
    typedef struct packed {
        tableEntry   entry;
        int unsigned cycle;
        int unsigned stalls;
    } pendingPacket;

    logic                    Clock;
    logic                    rst;
    logic                    inValid;
    logic                    stall;
    fetchPacket              fetchIn;
    wbPacket                 wb;
    logic [regAddrWidth-1:0] probeAddr;
    logic                    outValid;
    decodePacket             decodeOut;
    logic [dataWidth-1:0]    probeData;

    tableEntry            testTable[$];
    pendingPacket         expectQ[$];
    logic [dataWidth-1:0] shadow [32];   // Expected register contents
    logic [31:0]          lfsrState     = 32'hd264_1819;
    int unsigned          cycleCount    = 0;
    int unsigned          stallCount    = 0;
    int unsigned          mismatchCount = 0;
    int unsigned          otherErrors   = 0;
    logic                 loadedLast    = 1'b0;

    decodeStage #(.regDepth(32)) DUT (
        .Clock    (Clock    ),
        .rst      (rst      ),
        .inValid  (inValid  ),
        .stall    (stall    ),
        .fetchIn  (fetchIn  ),
        .wb       (wb       ),
        .probeAddr(probeAddr),
        .outValid (outValid ),
        .decodeOut(decodeOut),
        .probeData(probeData)
    );

    initial begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;
    end

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (stall) begin
            stallCount <= stallCount + 1;   // Each stalled edge adds a cycle of latency
        end
    end

    // ------------------------------
    // Random source and encoders
    // ------------------------------
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic logic [31:0] takeBits(input int unsigned count);
        logic [31:0] bits;
        bits = '0;
        for (int unsigned i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            bits      = {bits[30:0], lfsrState[0]};
        end
        return bits;
    endfunction

    function automatic logic [4:0] randReg();
        return 5'(takeBits(5));
    endfunction

    function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                            input logic [4:0] rd, input logic [4:0] shamt,
                                            input logic [5:0] funct);
        return {OP_RTYPE, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] signExt(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    // ------------------------------
    // Expected control sets
    // ------------------------------
    function automatic ctrlBundle aluCtrlR(input logic [5:0] funct);
        ctrlBundle c;
        c          = '0;
        c.regDst   = REGDST_RD;
        c.regWrite = 1'b1;
        c.aluOp    = 1'b1;
        c.aluFunc  = aluFuncCode'(funct);   // ALU code is the funct itself
        return c;
    endfunction

    function automatic ctrlBundle aluCtrlI(input aluFuncCode func, input logic zeroExt,
                                           input logic upper);
        ctrlBundle c;
        c             = '0;
        c.aluSrc      = 1'b1;
        c.aluOp       = 1'b1;
        c.regWrite    = 1'b1;
        c.aluFunc     = func;
        c.unsignedImm = zeroExt;
        c.shiftSel    = upper;
        return c;
    endfunction

    function automatic ctrlBundle branchCtrl(input aluFuncCode func);
        ctrlBundle c;
        c         = '0;
        c.branch  = 1'b1;
        c.aluOp   = 1'b1;
        c.aluFunc = func;
        return c;
    endfunction

    task automatic addEntry(input logic [31:0] instr, input ctrlBundle ctrl,
                            input logic [31:0] imm, input logic [4:0] dest);
        tableEntry e;
        e.instr     = instr;
        e.instrAddr = 32'h0040_0000 + 32'(testTable.size() * 4);
        e.ctrl      = ctrl;
        e.imm       = imm;
        e.dest      = dest;
        testTable.push_back(e);
    endtask

    task automatic buildTable();
        logic [5:0]  aluFuncts [12];
        logic [5:0]  opsI [6];
        aluFuncCode  funcsI [6];
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [25:0] target;
        logic        zeroExt;
        ctrlBundle   c;
        aluFuncts = '{ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_AND, ALU_OR,
                      ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA};
        opsI      = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI};
        funcsI    = '{ALU_ADD, ALU_ADDU, ALU_SLT, ALU_AND, ALU_OR, ALU_XOR};

        foreach (aluFuncts[i]) begin
            rd = randReg();
            addEntry(encodeR(randReg(), randReg(), rd, randReg(), aluFuncts[i]),
                     aluCtrlR(aluFuncts[i]), 32'h0, rd);
            testTable[testTable.size()-1].imm = signExt(testTable[testTable.size()-1].instr[15:0]);
        end
        c         = '0;
        c.jumpReg = 1'b1;
        rs        = randReg();
        addEntry(encodeR(rs, 5'd0, 5'd0, 5'd0, FN_JR), c, {26'd0, FN_JR}, 5'd0);
        c       = '0;
        c.mulOp = 1'b1;                      // No file write for mult
        rt      = randReg();
        addEntry(encodeR(randReg(), rt, 5'd0, 5'd0, FN_MULT), c, {26'd0, FN_MULT}, rt);

        // The last three register-immediate ALU ops zero-extend
        foreach (opsI[i]) begin
            rt      = randReg();
            imm     = 16'(takeBits(16)) | 16'h8000;   // Sign bit set so extension shows
            zeroExt = (i >= 3);
            addEntry(encodeI(opsI[i], randReg(), rt, imm), aluCtrlI(funcsI[i], zeroExt, 1'b0),
                     zeroExt ? {16'h0000, imm} : signExt(imm), rt);
        end
        rt  = randReg();
        imm = 16'(takeBits(16));
        addEntry(encodeI(OP_LUI, 5'd0, rt, imm), aluCtrlI(ALU_OR, 1'b0, 1'b1), {imm, 16'h0000}, rt);

        c          = aluCtrlI(ALU_ADDU, 1'b0, 1'b0);
        c.memRead  = 1'b1;
        c.memToReg = 1'b1;
        rt         = randReg();
        imm        = 16'(takeBits(16));
        addEntry(encodeI(OP_LW, randReg(), rt, imm), c, signExt(imm), rt);
        c          = aluCtrlI(ALU_ADDU, 1'b0, 1'b0);
        c.regWrite = 1'b0;
        c.memWrite = 1'b1;
        rt         = randReg();
        imm        = 16'(takeBits(16));
        addEntry(encodeI(OP_SW, randReg(), rt, imm), c, signExt(imm), rt);

        // Branches
        rt  = randReg();
        imm = 16'(takeBits(16));
        addEntry(encodeI(OP_BEQ, randReg(), rt, imm), branchCtrl(ALU_SUB), signExt(imm), rt);
        rt  = randReg();
        imm = 16'(takeBits(16));
        addEntry(encodeI(OP_BNE, randReg(), rt, imm), branchCtrl(ALU_SUB), signExt(imm), rt);
        imm = 16'(takeBits(16));
        addEntry(encodeI(OP_REGIMM, randReg(), RT_BLTZ, imm), branchCtrl(ALU_SLT),
                 signExt(imm), RT_BLTZ);
        imm = 16'(takeBits(16));
        addEntry(encodeI(OP_REGIMM, randReg(), RT_BGEZ, imm), branchCtrl(ALU_SLT),
                 signExt(imm), RT_BGEZ);

        // Jumps
        c         = '0;
        c.jump    = 1'b1;
        c.immSize = 1'b1;
        target    = 26'(takeBits(26));
        addEntry({OP_J, target}, c, {6'd0, target}, target[20:16]);
        c.regDst   = REGDST_RA;
        c.regWrite = 1'b1;
        target     = 26'(takeBits(26));
        addEntry({OP_JAL, target}, c, {6'd0, target}, 5'd31);

        // Undefined opcode, funct and REGIMM rt
        c         = '0;
        c.illegal = 1'b1;
        rt        = randReg();
        imm       = 16'(takeBits(16));
        addEntry(encodeI(6'h3f, randReg(), rt, imm), c, signExt(imm), rt);
        rt = randReg();
        addEntry(encodeR(randReg(), rt, randReg(), 5'd0, 6'h01), c, 32'h0, rt);
        testTable[testTable.size()-1].imm = signExt(testTable[testTable.size()-1].instr[15:0]);
        imm = 16'(takeBits(16));
        addEntry(encodeI(OP_REGIMM, randReg(), 5'h1f, imm), c, signExt(imm), 5'h1f);
    endtask

    // ------------------------------
    // Driving and checking
    // ------------------------------
    task automatic sendEntry(input tableEntry e);
        pendingPacket p;
        @(posedge Clock);
        fetchIn  <= '{instr: e.instr, instrAddr: e.instrAddr};
        inValid  <= 1'b1;
        p.entry  = e;
        p.cycle  = cycleCount;
        p.stalls = stallCount;
        expectQ.push_back(p);
    endtask

    task automatic waitDrained();
        while (expectQ.size() != 0) begin
            @(negedge Clock);
        end
    endtask

    task automatic checkField(input string name, input logic [31:0] instr,
                              input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s for instr %h got %h expected %h",
                     $time, name, instr, got, exp);
            mismatchCount++;
        end
    endtask

    task automatic checkPacket();
        pendingPacket p;
        tableEntry    e;
        int unsigned  expCycle;
        if (expectQ.size() == 0) begin
            $display("Unexpected valid packet at time %0t for address %h", $time,
                     decodeOut.instrAddr);
            otherErrors++;
        end else begin
            p        = expectQ.pop_front();
            e        = p.entry;
            expCycle = p.cycle + 3 + (stallCount - p.stalls);   // Two edges plus stalls
            checkField("ctrl", e.instr, 32'(decodeOut.ctrl), 32'(e.ctrl));
            checkField("rsData", e.instr, decodeOut.rsData, shadow[e.instr[25:21]]);
            checkField("rtData", e.instr, decodeOut.rtData, shadow[e.instr[20:16]]);
            checkField("immData", e.instr, decodeOut.immData, e.imm);
            checkField("instrAddr", e.instr, decodeOut.instrAddr, e.instrAddr);
            checkField("rsAddr", e.instr, 32'(decodeOut.rsAddr), 32'(e.instr[25:21]));
            checkField("rtAddr", e.instr, 32'(decodeOut.rtAddr), 32'(e.instr[20:16]));
            checkField("destAddr", e.instr, 32'(decodeOut.destAddr), 32'(e.dest));
            checkField("shamt", e.instr, 32'(decodeOut.shamt), 32'(e.instr[10:6]));
            checkField("arrival cycle", e.instr, cycleCount, expCycle);
        end
    endtask

    // New packet only when decodeReg loaded at the last edge
    always @(negedge Clock) begin
        if (!rst && outValid && loadedLast) begin
            checkPacket();
        end
        loadedLast = !rst && !stall;
    end

    initial begin
        wait (cycleCount >= cycleLimit);
        $display("Timeout: run still busy after %0d cycles", cycleLimit);
        $display("Errors: %0d mismatches, %0d other", mismatchCount, otherErrors);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        decodePacket heldOut;
        logic        heldValid;
        logic [31:0] newVal;
        tableEntry   wtEntry;
        rst       = 1'b1;
        inValid   = 1'b0;
        stall     = 1'b0;
        fetchIn   = '0;
        wb        = '0;
        probeAddr = '0;
        shadow    = '{default: '0};
        buildTable();
        repeat (5) @(posedge Clock);
        rst <= 1'b0;
        @(negedge Clock);
        if (outValid !== 1'b0) begin
            $display("Mismatch at %0t: outValid high after reset", $time);
            mismatchCount++;
        end

        // Preload every register, r0 included, then read back on the probe port
        for (int r = 0; r < 32; r++) begin
            @(posedge Clock);
            newVal = takeBits(32);
            wb <= '{regWrite: 1'b1, addr: 5'(r), data: newVal};
            if (r != 0) begin
                shadow[5'(r)] = newVal;
            end
        end
        @(posedge Clock);
        wb.regWrite <= 1'b0;
        for (int r = 0; r < 32; r++) begin
            @(posedge Clock);
            probeAddr <= 5'(r);
            @(negedge Clock);
            if (probeData !== shadow[5'(r)]) begin
                $display("Mismatch at %0t: probe of r%0d got %h expected %h",
                         $time, r, probeData, shadow[5'(r)]);
                mismatchCount++;
            end
        end

        // Decode table sent back to back
        foreach (testTable[i]) begin
            sendEntry(testTable[i]);
        end
        @(posedge Clock);
        inValid <= 1'b0;
        waitDrained();

        // Stall with one packet in each register
        sendEntry(testTable[0]);
        sendEntry(testTable[1]);
        @(posedge Clock);
        inValid <= 1'b0;
        stall   <= 1'b1;
        @(negedge Clock);
        heldOut   = decodeOut;
        heldValid = outValid;
        repeat (stallCycles) begin
            @(negedge Clock);
            if (outValid !== heldValid || decodeOut !== heldOut) begin
                $display("Mismatch at %0t: outputs changed while stalled", $time);
                mismatchCount++;
            end
        end
        @(posedge Clock);
        stall <= 1'b0;
        waitDrained();

        // Write-back to rs lands on the edge that samples the decode result
        wtEntry.instr     = encodeR(5'd7, 5'd9, 5'd3, 5'd0, ALU_ADDU);
        wtEntry.instrAddr = 32'h0040_1000;
        wtEntry.ctrl      = aluCtrlR(ALU_ADDU);
        wtEntry.imm       = signExt(wtEntry.instr[15:0]);
        wtEntry.dest      = 5'd3;
        sendEntry(wtEntry);
        @(posedge Clock);
        inValid <= 1'b0;
        newVal  = ~shadow[7];
        wb <= '{regWrite: 1'b1, addr: 5'd7, data: newVal};
        shadow[7] = newVal;
        @(posedge Clock);
        wb.regWrite <= 1'b0;
        waitDrained();
        probeAddr <= 5'd7;
        @(negedge Clock);
        if (probeData !== shadow[7]) begin
            $display("Mismatch at %0t: probe of r7 got %h expected %h", $time, probeData,
                     shadow[7]);
            mismatchCount++;
        end

        repeat (3) @(negedge Clock);   // Catch any late duplicate
        $display("Errors: %0d mismatches, %0d other", mismatchCount, otherErrors);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/decodePkg.sv
verilog/pipeReg.sv
verilog/controlDecoder.sv
verilog/regFile.sv
verilog/operandFormat.sv
verilog/decodeStage.sv
dv/decodeStageTb.sv

// ==== verilog/controlDecoder.sv ====
`default_nettype none

module controlDecoder import decodePkg::*; (
    input  wire logic [dataWidth-1:0] instr,
    output ctrlBundle                 ctrl
);

    logic [5:0]              opcode;
    logic [5:0]              funct;
    logic [regAddrWidth-1:0] rtField;
    logic                    legal;

    assign opcode  = instr[31:26];
    assign funct   = instr[5:0];
    assign rtField = instr[20:16]; // Branch kind for REGIMM

    // ------------------------------
    // Opcode decode
    // ------------------------------
    always_comb begin
        ctrl  = '0;
        legal = 1'b1;
        case (opcode)
            OP_RTYPE: begin
                case (funct)
                    ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
                    ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
                    ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA: begin
                        ctrl.regDst   = REGDST_RD;
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = 1'b1;
                        ctrl.aluFunc  = aluFuncCode'(funct);
                    end
                    FN_JR:   ctrl.jumpReg = 1'b1;
                    FN_MULT: ctrl.mulOp   = 1'b1; // Product goes to hi/lo, not the file
                    default: legal = 1'b0;
                endcase
            end
            OP_REGIMM: begin
                case (rtField)
                    RT_BLTZ, RT_BGEZ: begin
                        ctrl.branch  = 1'b1;
                        ctrl.aluOp   = 1'b1;
                        ctrl.aluFunc = ALU_SLT; // Sign test against zero
                    end
                    default: legal = 1'b0;
                endcase
            end
            OP_J: begin
                ctrl.jump    = 1'b1;
                ctrl.immSize = 1'b1;
            end
            OP_JAL: begin
                ctrl.jump     = 1'b1;
                ctrl.immSize  = 1'b1;
                ctrl.regDst   = REGDST_RA;
                ctrl.regWrite = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.branch  = 1'b1;
                ctrl.aluOp   = 1'b1;
                ctrl.aluFunc = ALU_SUB;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = 1'b1;
                ctrl.regWrite = 1'b1;
                case (opcode)
                    OP_ADDI:  ctrl.aluFunc = ALU_ADD;
                    OP_ADDIU: ctrl.aluFunc = ALU_ADDU; // Still sign-extended
                    OP_SLTI:  ctrl.aluFunc = ALU_SLT;
                    OP_ANDI: begin
                        ctrl.aluFunc     = ALU_AND;
                        ctrl.unsignedImm = 1'b1;
                    end
                    OP_ORI: begin
                        ctrl.aluFunc     = ALU_OR;
                        ctrl.unsignedImm = 1'b1;
                    end
                    OP_XORI: begin
                        ctrl.aluFunc     = ALU_XOR;
                        ctrl.unsignedImm = 1'b1;
                    end
                    default: begin
                        // lui, rs is zero so or passes the shifted immediate
                        ctrl.aluFunc  = ALU_OR;
                        ctrl.shiftSel = 1'b1;
                    end
                endcase
            end
            OP_LW: begin
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluFunc  = ALU_ADDU; // Base plus offset
            end
            OP_SW: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = 1'b1;
                ctrl.aluFunc  = ALU_ADDU;
            end
            default: legal = 1'b0;
        endcase

        // Unknown encodings drop every control
        if (!legal) begin
            ctrl         = '0;
            ctrl.illegal = 1'b1;
        end
    end

    // A load and a store in one packet would clash at the memory stage
    always_comb begin
        memExclusive: assert (!(ctrl.memRead && ctrl.memWrite))
            else $error("controlDecoder: memRead and memWrite both set");
    end

endmodule

`default_nettype wire

// ==== verilog/decodePkg.sv ====
`default_nettype none

package decodePkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;

    // ALU operations, numbered as the MIPS funct field
    typedef enum logic [5:0] {
        ALU_SLL  = 6'h00,
        ALU_SRL  = 6'h02,
        ALU_SRA  = 6'h03,
        ALU_ADD  = 6'h20,
        ALU_ADDU = 6'h21,
        ALU_SUB  = 6'h22,
        ALU_SUBU = 6'h23,
        ALU_AND  = 6'h24,
        ALU_OR   = 6'h25,
        ALU_XOR  = 6'h26,
        ALU_NOR  = 6'h27,
        ALU_SLT  = 6'h2a
    } aluFuncCode;

    // ------------------------------
    // Opcodes
    // ------------------------------
    localparam logic [5:0] OP_RTYPE  = 6'h00;
    localparam logic [5:0] OP_REGIMM = 6'h01;
    localparam logic [5:0] OP_J      = 6'h02;
    localparam logic [5:0] OP_JAL    = 6'h03;
    localparam logic [5:0] OP_BEQ    = 6'h04;
    localparam logic [5:0] OP_BNE    = 6'h05;
    localparam logic [5:0] OP_ADDI   = 6'h08;
    localparam logic [5:0] OP_ADDIU  = 6'h09;
    localparam logic [5:0] OP_SLTI   = 6'h0a;
    localparam logic [5:0] OP_ANDI   = 6'h0c;
    localparam logic [5:0] OP_ORI    = 6'h0d;
    localparam logic [5:0] OP_XORI   = 6'h0e;
    localparam logic [5:0] OP_LUI    = 6'h0f;
    localparam logic [5:0] OP_LW     = 6'h23;
    localparam logic [5:0] OP_SW     = 6'h2b;

    // R-type functs outside the ALU set
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_MULT = 6'h18;

    // REGIMM rt field
    localparam logic [4:0] RT_BLTZ = 5'h00;
    localparam logic [4:0] RT_BGEZ = 5'h01;

    // Destination select
    localparam logic [1:0] REGDST_RT = 2'd0;
    localparam logic [1:0] REGDST_RD = 2'd1;
    localparam logic [1:0] REGDST_RA = 2'd2;

    localparam logic [regAddrWidth-1:0] REG_RA = 5'd31; // Return address for jal

    // ------------------------------
    // Packets
    // ------------------------------
    typedef struct packed {
        logic [dataWidth-1:0] instr;
        logic [dataWidth-1:0] instrAddr;
    } fetchPacket;

    typedef struct packed {
        logic                    regWrite;
        logic [regAddrWidth-1:0] addr;
        logic [dataWidth-1:0]    data;
    } wbPacket;

    typedef struct packed {
        logic       branch;
        logic       jump;
        logic       jumpReg;
        logic       memRead;
        logic       memToReg;
        logic       memWrite;
        logic       aluSrc;
        logic       aluOp;
        logic       mulOp;
        logic       regWrite;
        logic       illegal;
        aluFuncCode aluFunc;
        logic [1:0] regDst;
        logic       shiftSel;    // Steering for operandFormat only
        logic       immSize;
        logic       unsignedImm;
    } ctrlBundle;

    typedef struct packed {
        ctrlBundle               ctrl;
        logic [dataWidth-1:0]    rsData;
        logic [dataWidth-1:0]    rtData;
        logic [dataWidth-1:0]    immData;
        logic [dataWidth-1:0]    instrAddr;
        logic [regAddrWidth-1:0] rsAddr;
        logic [regAddrWidth-1:0] rtAddr;
        logic [regAddrWidth-1:0] destAddr;
        logic [regAddrWidth-1:0] shamt;
    } decodePacket;

endpackage

`default_nettype wire

// ==== verilog/decodeStage.sv ====
`default_nettype none

module decodeStage import decodePkg::*; #(
    parameter int regDepth = 32
) (
    input  wire logic                    Clock,
    input  wire logic                    rst,
    input  wire logic                    inValid,
    input  wire logic                    stall,
    input  wire fetchPacket              fetchIn,
    input  wire wbPacket                 wb,
    input  wire logic [regAddrWidth-1:0] probeAddr,
    output logic                         outValid,
    output decodePacket                  decodeOut,
    output logic      [dataWidth-1:0]    probeData
);

    fetchPacket              fetchQ;
    logic                    fetchValid;
    ctrlBundle               ctrl;
    logic [dataWidth-1:0]    rsData;
    logic [dataWidth-1:0]    rtData;
    logic [dataWidth-1:0]    immData;
    logic [regAddrWidth-1:0] destAddr;
    decodePacket             decodeNext;

    // ------------------------------
    // Fetch side register
    // ------------------------------
    pipeReg #(.payloadType(fetchPacket)) fetchReg (
        .Clock   (Clock     ),
        .rst     (rst       ),
        .stall   (stall     ),
        .inValid (inValid   ),
        .dataIn  (fetchIn   ),
        .outValid(fetchValid),
        .dataOut (fetchQ    )
    );

    // ------------------------------
    // Decode logic
    // ------------------------------
    controlDecoder ctrlDec (
        .instr(fetchQ.instr),
        .ctrl (ctrl        )
    );

    regFile #(.depth(regDepth)) regs (
        .Clock    (Clock               ),
        .rst      (rst                 ),
        .wb       (wb                  ),
        .rsAddr   (fetchQ.instr[25:21] ),
        .rtAddr   (fetchQ.instr[20:16] ),
        .probeAddr(probeAddr           ),
        .rsData   (rsData              ),
        .rtData   (rtData              ),
        .probeData(probeData           )
    );

    operandFormat opFmt (
        .instr   (fetchQ.instr),
        .ctrl    (ctrl        ),
        .immData (immData     ),
        .destAddr(destAddr    )
    );

    assign decodeNext = '{
        ctrl:      ctrl,
        rsData:    rsData,
        rtData:    rtData,
        immData:   immData,
        instrAddr: fetchQ.instrAddr,
        rsAddr:    fetchQ.instr[25:21],
        rtAddr:    fetchQ.instr[20:16],
        destAddr:  destAddr,
        shamt:     fetchQ.instr[10:6]
    };

    // ------------------------------
    // Output register
    // ------------------------------
    pipeReg #(.payloadType(decodePacket)) decodeReg (
        .Clock   (Clock     ),
        .rst     (rst       ),
        .stall   (stall     ),
        .inValid (fetchValid),
        .dataIn  (decodeNext),
        .outValid(outValid  ),
        .dataOut (decodeOut )
    );

endmodule

`default_nettype wire

// ==== verilog/operandFormat.sv ====
`default_nettype none

module operandFormat import decodePkg::*; (
    input  wire logic      [dataWidth-1:0]    instr,
    input  wire ctrlBundle                    ctrl,
    output logic           [dataWidth-1:0]    immData,
    output logic           [regAddrWidth-1:0] destAddr
);

    logic [15:0]             imm16;
    logic [25:0]             target;
    logic [dataWidth-1:0]    extImm;
    logic [regAddrWidth-1:0] rtField;
    logic [regAddrWidth-1:0] rdField;

    assign imm16   = instr[15:0];
    assign target  = instr[25:0];
    assign rtField = instr[20:16];
    assign rdField = instr[15:11];

    // ------------------------------
    // Immediate
    // ------------------------------
    assign extImm = ctrl.unsignedImm ? {16'h0000, imm16}
                                     : {{16{imm16[15]}}, imm16};

    always_comb begin
        if (ctrl.immSize) begin
            immData = {6'd0, target}; // Jump target, word index
        end else if (ctrl.shiftSel) begin
            immData = {imm16, 16'h0000}; // lui
        end else begin
            immData = extImm;
        end
    end

    // ------------------------------
    // Destination register
    // ------------------------------
    always_comb begin
        case (ctrl.regDst)
            REGDST_RD: destAddr = rdField;
            REGDST_RA: destAddr = REG_RA; // Link for jal
            default:   destAddr = rtField;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/pipeReg.sv ====
`default_nettype none

module pipeReg #(
    parameter type payloadType = logic [31:0]
) (
    input  wire logic       Clock,
    input  wire logic       rst,
    input  wire logic       stall,
    input  wire logic       inValid,
    input  wire payloadType dataIn,
    output logic            outValid,
    output payloadType      dataOut
);

    // Stall freezes the whole stage at once
    always_ff @(posedge Clock) begin
        if (rst) begin
            outValid <= 1'b0;
            dataOut  <= '0;
        end else if (!stall) begin
            outValid <= inValid;
            dataOut  <= dataIn;
        end
    end

    // Back-pressure must not lose or alter a held packet
    holdOnStall: assert property (
        @(posedge Clock) disable iff (rst)
        stall |=> ($stable(dataOut) && $stable(outValid))
    ) else $error("pipeReg: contents changed while stalled");

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
`default_nettype none

module regFile import decodePkg::*; #(
    parameter int depth = 32
) (
    input  wire logic                    Clock,
    input  wire logic                    rst,
    input  wire wbPacket                 wb,
    input  wire logic [regAddrWidth-1:0] rsAddr,
    input  wire logic [regAddrWidth-1:0] rtAddr,
    input  wire logic [regAddrWidth-1:0] probeAddr,
    output logic      [dataWidth-1:0]    rsData,
    output logic      [dataWidth-1:0]    rtData,
    output logic      [dataWidth-1:0]    probeData
);

    logic [dataWidth-1:0] regs [depth];
    logic                 writeEn;

    // Writes to r0 are dropped
    assign writeEn = wb.regWrite && (wb.addr != '0);

    // ------------------------------
    // Write port
    // ------------------------------
    always_ff @(posedge Clock) begin
        if (writeEn) begin
            regs[wb.addr] <= wb.data;
        end
        regs[0] <= '0; // Hardwired zero
    end

    // ------------------------------
    // Read ports
    // ------------------------------
    // Decode reads see a write landing on the same edge
    assign rsData = (writeEn && (wb.addr == rsAddr)) ? wb.data : regs[rsAddr];
    assign rtData = (writeEn && (wb.addr == rtAddr)) ? wb.data : regs[rtAddr];

    // Probe shows stored contents only
    assign probeData = regs[probeAddr];

    // r0 storage must stay clear, since reads of address 0 come straight from it
    r0Clear: assert property (@(posedge Clock) disable iff (rst) regs[0] == '0)
        else $error("regFile: register 0 holds a nonzero value");

endmodule

`default_nettype wire
